//--- common/decim_pkg.sv
package decim_pkg;

    // Raw converter sample width
    localparam int sample_width = 16;

    // Number of channels interleaved on the input stream
    localparam int n_channels = 4;

    // Largest supported decimation ratio, and the bits needed to count up to it
    localparam int max_ratio = 16;
    localparam int ratio_width = $clog2(max_ratio);

    // Bits of a channel number
    localparam int channel_width = $clog2(n_channels);

    // Width of the scan counter carried in the user field
    localparam int user_width = 8;

    // Signed raw sample as it arrives from the converter
    typedef logic signed [sample_width-1:0] sample_t;

    // Accumulator wide enough for a full block of max_ratio samples
    typedef logic signed [sample_width+ratio_width-1:0] accum_t;

    // Decimation ratio or averaging shift
    typedef logic [ratio_width-1:0] ratio_t;

    // Channel number, carried in the dest field
    typedef logic [channel_width-1:0] channel_t;

    // Count of complete scans over all channels
    typedef logic [user_width-1:0] scan_t;

    // Output data word of the stream
    typedef logic [31:0] word_t;

    // Beat from the sequencer to the decimator
    typedef struct packed {
        sample_t  data;
        channel_t dest;
        scan_t    user;
        logic     last;
    } tagged_beat_t;

    // Beat leaving the decimator, data sign-extended to a full word
    typedef struct packed {
        word_t    data;
        channel_t dest;
        scan_t    user;
        logic     last;
    } out_beat_t;

endpackage

//--- rtl/channel_sequencer.sv
`timescale 1ns/10ps

module channel_sequencer
    import decim_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         sample_valid,
    input  sample_t      sample_data,
    output logic         sample_ready,
    output tagged_beat_t tag_beat,
    output logic         tag_valid,
    input  logic         tag_ready
);

    channel_t channel;
    scan_t    scan;
    logic     load;
    logic     last_channel;

    // The stage can take a new sample when empty or when its beat leaves now
    assign sample_ready = !tag_valid || tag_ready;
    assign load = sample_valid && sample_ready;

    assign last_channel = (channel == channel_t'(n_channels - 1));

    // Control state: occupancy, channel position and scan count
    always_ff @(posedge clock) begin
        if (!reset) begin
            tag_valid <= 1'b0;
            channel <= '0;
            scan <= '0;
        end else begin
            if (load) begin
                tag_valid <= 1'b1;
                if (last_channel) begin
                    channel <= '0;
                    // A scan is complete once its last channel is accepted
                    scan <= scan + 1'b1;
                end else begin
                    channel <= channel + 1'b1;
                end
            end else if (tag_ready) begin
                tag_valid <= 1'b0;
            end
        end
    end

    // Payload register, loaded only together with the occupancy flag
    always_ff @(posedge clock) begin
        if (load) begin
            tag_beat <= '{
                data: sample_data,
                dest: channel,
                user: scan,
                last: last_channel
            };
        end
    end

    // A beat waiting for the decimator must keep its tags and data
    property p_tag_held;
        @(posedge clock) disable iff (!reset)
            tag_valid && !tag_ready |=> tag_valid && $stable(tag_beat);
    endproperty

    a_tag_held: assert property (p_tag_held)
        else $error("tagged beat changed while stalled");

endmodule

//--- decimator/standard_decimator.sv
`timescale 1ns/10ps

module standard_decimator
    import decim_pkg::*;
(
    input  logic         clock,
    input  logic         reset,

    // Tagged sample stream from the sequencer
    input  tagged_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,

    // Decimated output stream
    output out_beat_t    out_beat,
    output logic         out_valid,
    input  logic         out_ready,

    // Configuration, static while samples flow
    input  ratio_t       decimation_ratio,
    input  logic         avg_enable,
    input  ratio_t       avg_shift
);

    // Per-channel block position and running sum
    ratio_t   count [n_channels];
    accum_t   accum [n_channels];

    channel_t channel;
    logic     in_fire;
    ratio_t   block_last;
    logic     block_end;
    accum_t   sample_ext;
    accum_t   block_sum;
    accum_t   block_mean;
    word_t    result;

    // Ready passes straight through, so a held output blocks the input as well
    assign in_ready = out_ready;
    assign in_fire = in_valid && out_ready;

    assign channel = in_beat.dest;

    // Sample widened to accumulator width
    assign sample_ext = {{ratio_width{in_beat.data[sample_width-1]}}, in_beat.data};

    // Index of the beat that closes a block for the selected mode
    always_comb begin
        if (avg_enable) begin
            block_last = ratio_t'((1 << avg_shift) - 1);
        end else begin
            block_last = ratio_t'(decimation_ratio - 1);
        end
    end

    // A ratio of zero in picking mode lets every sample through
    assign block_end = (count[channel] == block_last)
                    || (!avg_enable && (decimation_ratio == '0));

    // Sum including the current beat, then the mean by arithmetic shift
    assign block_sum = accum[channel] + sample_ext;
    assign block_mean = block_sum >>> avg_shift;

    always_comb begin
        if (avg_enable) begin
            result = {{($bits(word_t) - $bits(accum_t)){block_mean[$bits(accum_t)-1]}},
                      block_mean};
        end else begin
            result = {{($bits(word_t) - sample_width){in_beat.data[sample_width-1]}},
                      in_beat.data};
        end
    end

    // Counters, accumulators and output occupancy
    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
            for (int i = 0; i < n_channels; i++) begin
                count[i] <= '0;
                accum[i] <= '0;
            end
        end else begin
            // The current beat leaves; a new one below may take its place
            if (out_ready) begin
                out_valid <= 1'b0;
            end
            if (in_fire) begin
                if (block_end) begin
                    count[channel] <= '0;
                    accum[channel] <= '0;
                    out_valid <= 1'b1;
                end else begin
                    count[channel] <= count[channel] + 1'b1;
                    accum[channel] <= block_sum;
                end
            end
        end
    end

    // Output payload, tags copied from the beat that completed the block
    always_ff @(posedge clock) begin
        if (in_fire && block_end) begin
            out_beat <= '{
                data: result,
                dest: in_beat.dest,
                user: in_beat.user,
                last: in_beat.last
            };
        end
    end

    // An offered output must stay put until the sink takes it
    property p_out_held;
        @(posedge clock) disable iff (!reset)
            out_valid && !out_ready |=> out_valid && $stable(out_beat);
    endproperty

    a_out_held: assert property (p_out_held)
        else $error("output beat dropped or changed before acceptance");

    // Blocks longer than the accumulator headroom would overflow
    property p_shift_range;
        @(posedge clock) disable iff (!reset)
            avg_enable |-> (avg_shift <= ratio_t'(ratio_width));
    endproperty

    a_shift_range: assert property (p_shift_range)
        else $error("averaging shift exceeds accumulator headroom");

endmodule

//--- rtl/decimation_chain.sv
`timescale 1ns/10ps

module decimation_chain
    import decim_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    // Interleaved sample input
    input  logic      sample_valid,
    input  sample_t   sample_data,
    output logic      sample_ready,

    // Decimator configuration
    input  ratio_t    decimation_ratio,
    input  logic      avg_enable,
    input  ratio_t    avg_shift,

    // Decimated output stream
    output out_beat_t out_beat,
    output logic      out_valid,
    input  logic      out_ready
);

    // Link between sequencer and decimator
    tagged_beat_t tag_beat;
    logic         tag_valid;
    logic         tag_ready;

    channel_sequencer u_sequencer (
        .clock        (clock),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .sample_ready (sample_ready),
        .tag_beat     (tag_beat),
        .tag_valid    (tag_valid),
        .tag_ready    (tag_ready)
    );

    standard_decimator u_decimator (
        .clock            (clock),
        .reset            (reset),
        .in_beat          (tag_beat),
        .in_valid         (tag_valid),
        .in_ready         (tag_ready),
        .out_beat         (out_beat),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .decimation_ratio (decimation_ratio),
        .avg_enable       (avg_enable),
        .avg_shift        (avg_shift)
    );

endmodule

//--- sim/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
    output logic clock,
    output logic reset,
    input  logic reset_request
);

    localparam int half_period = 2;
    localparam int reset_cycles = 10;

    logic reset_reg = 1'b0;
    int   reset_count = reset_cycles;

    assign reset = reset_reg;

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    // Reset is held low for reset_cycles rising edges after start or after a request
    always @(posedge clock) begin
        if (reset_request) begin
            reset_reg <= 1'b0;
            reset_count <= reset_cycles;
        end else if (reset_count > 0) begin
            reset_count <= reset_count - 1;
            if (reset_count == 1) begin
                reset_reg <= 1'b1;
            end
        end
    end

endmodule

//--- sim/decimation_chain_tb.sv
`timescale 1ns/10ps

module decimation_chain_tb
    import decim_pkg::*;
;

    localparam int samples_per_phase = 200;
    localparam int feed_limit = 2000;
    localparam int drain_limit = 500;
    localparam int reset_limit = 50;

    // Expected output beat and the cycle it must appear in when latency is fixed
    typedef struct packed {
        out_beat_t beat;
        int        due;
    } expected_t;

    logic      clock;
    logic      reset;
    logic      reset_request;
    logic      sample_valid;
    sample_t   sample_data;
    logic      sample_ready;
    ratio_t    decimation_ratio;
    logic      avg_enable;
    ratio_t    avg_shift;
    out_beat_t out_beat;
    logic      out_valid;
    logic      out_ready;

    logic [31:0] lcg_state;
    logic        strict_latency;
    bit          backpressure_on;
    bit          stall_seen;
    int          accepted;

    // Reference model state
    expected_t   expected_queue[$];
    int          model_count [n_channels];
    int          model_sum [n_channels];
    channel_t    model_channel;
    scan_t       model_scan;
    logic        seq_full;
    logic        hold_pending;
    out_beat_t   held_beat;
    int          cycle_count;

    clock_gen u_clock_gen (
        .clock         (clock),
        .reset         (reset),
        .reset_request (reset_request)
    );

    decimation_chain u_dut (
        .clock            (clock),
        .reset            (reset),
        .sample_valid     (sample_valid),
        .sample_data      (sample_data),
        .sample_ready     (sample_ready),
        .decimation_ratio (decimation_ratio),
        .avg_enable       (avg_enable),
        .avg_shift        (avg_shift),
        .out_beat         (out_beat),
        .out_valid        (out_valid),
        .out_ready        (out_ready)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic verify_equal(input string name, input logic [63:0] actual,
                                input logic [63:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH at %0t: %s got %0h expected %0h",
                                $time, name, actual, expected));
        end
    endtask

    // Reference model of one accepted sample with its tags and block result
    task automatic model_accept(input sample_t s);
        expected_t e;
        int        value;
        int        block_len;
        channel_t  dest;
        logic      last;
        dest = model_channel;
        last = (model_channel == channel_t'(n_channels - 1));
        value = int'(s);
        model_count[dest]++;
        model_sum[dest] += value;
        if (avg_enable) begin
            block_len = 1 << avg_shift;
        end else begin
            block_len = int'(decimation_ratio);
        end
        if (block_len == 0 || model_count[dest] == block_len) begin
            if (avg_enable) begin
                e.beat.data = word_t'(model_sum[dest] >>> avg_shift);
            end else begin
                e.beat.data = word_t'(value);
            end
            e.beat.dest = dest;
            e.beat.user = model_scan;
            e.beat.last = last;
            e.due = cycle_count + 2;
            expected_queue.push_back(e);
            model_count[dest] = 0;
            model_sum[dest] = 0;
        end
        if (last) begin
            model_channel = '0;
            model_scan = scan_t'(model_scan + 1);
        end else begin
            model_channel = channel_t'(model_channel + 1);
        end
    endtask

    task automatic check_output();
        expected_t e;
        if (expected_queue.size() == 0) begin
            abort_run("An output beat appeared with no expected result");
        end
        e = expected_queue.pop_front();
        verify_equal("out_beat.data", 64'(out_beat.data), 64'(e.beat.data));
        verify_equal("out_beat.dest", 64'(out_beat.dest), 64'(e.beat.dest));
        verify_equal("out_beat.user", 64'(out_beat.user), 64'(e.beat.user));
        verify_equal("out_beat.last", 64'(out_beat.last), 64'(e.beat.last));
        if (strict_latency) begin
            verify_equal("output latency", 64'(cycle_count), 64'(e.due));
        end
    endtask

    // Monitor samples pre-edge values, the same ones the DUT registers see
    always @(posedge clock) begin
        cycle_count++;
        if (!reset) begin
            for (int i = 0; i < n_channels; i++) begin
                model_count[i] = 0;
                model_sum[i] = 0;
            end
            model_channel = '0;
            model_scan = '0;
            seq_full = 1'b0;
            hold_pending = 1'b0;
        end else begin
            if (hold_pending) begin
                verify_equal("out_valid while held", 64'(out_valid), 64'(1'b1));
                verify_equal("out_beat while held", 64'(out_beat), 64'(held_beat));
            end
            verify_equal("sample_ready", 64'(sample_ready), 64'(!seq_full || out_ready));
            if (out_valid && out_ready) begin
                check_output();
            end
            if (sample_valid && sample_ready) begin
                model_accept(sample_data);
                seq_full = 1'b1;
            end else if (out_ready) begin
                seq_full = 1'b0;
            end
            hold_pending = out_valid && !out_ready;
            held_beat = out_beat;
        end
    end

    task automatic drive_cycle(input bit allow_new);
        logic [31:0] r;
        @(posedge clock);
        if (sample_valid && sample_ready) begin
            accepted++;
        end
        if (!sample_ready) begin
            stall_seen = 1'b1;
        end
        // A beat that has not transferred stays on the input unchanged
        if (!sample_valid || sample_ready) begin
            r = next_random();
            if (allow_new && r[31:30] != 2'b00) begin
                r = next_random();
                sample_valid <= 1'b1;
                sample_data <= sample_t'(r[31:16]);
            end else begin
                sample_valid <= 1'b0;
            end
        end
        r = next_random();
        out_ready <= !backpressure_on || (r[31:30] != 2'b00);
    endtask

    // Configuration changes only while idle, then the chain is reset
    task automatic apply_reset(input logic avg, input ratio_t ratio, input ratio_t shift,
                               input bit backpressure, input logic strict);
        int cycles;
        @(posedge clock);
        sample_valid <= 1'b0;
        out_ready <= 1'b0;
        avg_enable <= avg;
        decimation_ratio <= ratio;
        avg_shift <= shift;
        strict_latency <= strict;
        reset_request <= 1'b1;
        backpressure_on = backpressure;
        stall_seen = 1'b0;
        @(posedge clock);
        reset_request <= 1'b0;
        cycles = 0;
        @(posedge clock);
        while (!reset) begin
            if (cycles >= reset_limit) begin
                abort_run("Timeout waiting for reset release");
            end
            @(posedge clock);
            cycles++;
        end
    endtask

    task automatic run_phase(input logic avg, input ratio_t ratio, input ratio_t shift,
                             input bit backpressure, input logic strict);
        int cycles;
        bit done;
        apply_reset(avg, ratio, shift, backpressure, strict);
        accepted = 0;
        cycles = 0;
        while (accepted < samples_per_phase) begin
            if (cycles >= feed_limit) begin
                abort_run("Timeout waiting for input samples to be accepted");
            end
            drive_cycle(1'b1);
            cycles++;
        end
        cycles = 0;
        done = 1'b0;
        while (!done) begin
            if (cycles >= drain_limit) begin
                abort_run("Timeout waiting for the chain to drain");
            end
            drive_cycle(1'b0);
            cycles++;
            @(negedge clock);
            done = !sample_valid && (expected_queue.size() == 0);
        end
        // A few quiet cycles catch any extra output beat
        repeat (8) drive_cycle(1'b0);
        if (backpressure && !stall_seen) begin
            abort_run("sample_ready never dropped under output back-pressure");
        end
    endtask

    initial begin
        lcg_state = 32'hc2a;
        cycle_count = 0;
        sample_valid <= 1'b0;
        sample_data <= '0;
        out_ready <= 1'b0;
        decimation_ratio <= '0;
        avg_enable <= 1'b0;
        avg_shift <= '0;
        reset_request <= 1'b0;
        strict_latency <= 1'b0;

        // Picking by 4 with a free-running sink and a fixed two-cycle latency
        run_phase(1'b0, ratio_t'(4), ratio_t'(0), 1'b0, 1'b1);
        // Ratio 0 passes every sample
        run_phase(1'b0, ratio_t'(0), ratio_t'(0), 1'b1, 1'b0);
        // Averaging over blocks of 4 and of 8
        run_phase(1'b1, ratio_t'(0), ratio_t'(2), 1'b1, 1'b0);
        run_phase(1'b1, ratio_t'(0), ratio_t'(3), 1'b1, 1'b0);
        run_phase(1'b0, ratio_t'(3), ratio_t'(0), 1'b1, 1'b0);

        @(negedge clock);
        if (expected_queue.size() != 0) begin
            abort_run("Expected output beats never appeared");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

//--- sim.f
common/decim_pkg.sv
rtl/channel_sequencer.sv
decimator/standard_decimator.sv
rtl/decimation_chain.sv
sim/clock_gen.sv
sim/decimation_chain_tb.sv

//--- Makefile
# Verilator build and run for the decimation chain testbench

VERILATOR       ?= verilator
TOP             ?= decimation_chain_tb
FILE_LIST       ?= sim.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

$(SIM_BIN):
	$(MAKE) compile

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
